// File: build.f
hdl/infPkg.sv
hdl/arrayReader.sv
hdl/addrGen.sv
hdl/macSeq.sv
hdl/lbWriteback.sv
hdl/layerSeq.sv
hdl/infCtrlTop.sv
tests/infCtrlTb.sv

// File: hdl/addrGen.sv
// Address generation for the array and the line buffer. Commands from the
// layer FSM take effect on the next edge.
`timescale 1ns/10ps

module addrGen (
   input  logic                        CLK,
   input  logic                        RST_l,
   input  infPkg::addrCmd_t            cmd_i,
   input  logic                        rdDone_i,
   input  infPkg::sparseWord_t         sparse_i,
   input  logic [infPkg::ArrAddrW-1:0] arStart_i,
   input  logic [infPkg::LbAddrW-1:0]  lbStart_i,
   input  logic [infPkg::LbAddrW-1:0]  lbTemp_i,
   input  logic [infPkg::LbAddrW-1:0]  tempIdx_i,
   input  logic                        wbActive_i,
   output logic [infPkg::ArrAddrW-1:0] arrAddr_o,
   output logic [infPkg::LbAddrW-1:0]  lbAddr_o
);
   import infPkg::*;

   logic [ArrAddrW-1:0] offset;
   logic [LbAddrW-1:0]  denseIdx;
   logic [LbAddrW-1:0]  operand;

   // Offset walks one word per completed read
   always_ff @(posedge CLK) begin
      if (RST_l) begin
         offset   <= '0;
         denseIdx <= '0;
      end else begin
         if (cmd_i.clrLayer) begin
            offset <= '0;
         end else if (rdDone_i) begin
            offset <= offset + 1'b1;
         end

         if (cmd_i.clrNeuron) begin
            denseIdx <= '0;
         end else if (cmd_i.loadDense) begin
            denseIdx <= denseIdx + 1'b1;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (cmd_i.loadDense) begin
         operand <= denseIdx;
      end else if (cmd_i.loadSparse) begin
         operand <= sparse_i.idx[cmd_i.slot];
      end
   end

   assign arrAddr_o = arStart_i + offset;

   // Temp region owns the bus while lanes are written back
   assign lbAddr_o = wbActive_i ? lbTemp_i + tempIdx_i : lbStart_i + operand;

endmodule

// File: hdl/arrayReader.sv
// Array read engine. Holds the request until acknowledged, registers the
// returned word and pulses rdDone_o the cycle after the capture.
`timescale 1ns/10ps

module arrayReader (
   input  logic                     CLK,
   input  logic                     RST_l,
   input  logic                     rdGo_i,
   input  logic                     arrAck_i,
   input  logic [infPkg::DataW-1:0] arrData_i,
   output logic                     arrReq_o,
   output logic                     rdDone_o,
   output infPkg::arrayWord_u       rdWord_o
);
   import infPkg::*;

   logic accepted;

   assign accepted = arrReq_o && arrAck_i;

   always_ff @(posedge CLK) begin
      if (RST_l) begin
         arrReq_o <= 1'b0;
         rdDone_o <= 1'b0;
      end else begin
         rdDone_o <= accepted;
         if (accepted) begin
            arrReq_o <= 1'b0;
         end else if (rdGo_i) begin
            arrReq_o <= 1'b1;
         end
      end
   end

   // Data is valid on the edge that sees the acknowledge
   always_ff @(posedge CLK) begin
      if (accepted) begin
         rdWord_o <= arrayWord_u'(arrData_i);
      end
   end

endmodule

// File: hdl/infCtrlTop.sv
// Top level of the inference sequencing controller. Wires the layer FSM to
// the array reader, address generator, MAC sequencer and writeback.
`timescale 1ns/10ps

module infCtrlTop #(
   parameter int MultSteps = 9
) (
   input  logic                        CLK,
   input  logic                        RST_l,
   input  logic                        sts_i,
   input  logic [infPkg::ArrAddrW-1:0] arStart_i,
   input  logic [infPkg::LbAddrW-1:0]  lbStart_i,
   input  logic [infPkg::LbAddrW-1:0]  lbTemp_i,
   input  logic                        arrAck_i,
   input  logic [infPkg::DataW-1:0]    arrData_i,
   output logic                        arrReq_o,
   output logic [infPkg::ArrAddrW-1:0] arrAddr_o,
   output logic [infPkg::LbAddrW-1:0]  lbAddr_o,
   output logic                        lbRead_o,
   output logic                        lbWrite_o,
   output logic                        resetAcc_o,
   output logic                        resetMult_o,
   output logic                        latchMult_o,
   output logic                        latchAcc_o,
   output logic                        macBusEn_o,
   output logic [1:0]                  macSel_o,
   output logic [infPkg::MacLanes-1:0] biasCk_o,
   output logic                        biasSel_o,
   output logic                        done_o
);
   import infPkg::*;

   logic               rdGo;
   logic               rdDone;
   arrayWord_u         rdWord;
   addrCmd_t           addrCmd;
   sparseWord_t        sparseWord;
   logic               macGo;
   logic               firstInp;
   logic               macDone;
   logic               wbGo;
   logic               wbDone;
   logic [LbAddrW-1:0] tempIdx;
   logic               wbActive;

   //------------------------------------------------------------------------
   // Control
   layerSeq u_layerSeq (
      .CLK        (CLK),
      .RST_l      (RST_l),
      .sts_i      (sts_i),
      .rdDone_i   (rdDone),
      .rdWord_i   (rdWord),
      .macDone_i  (macDone),
      .wbDone_i   (wbDone),
      .rdGo_o     (rdGo),
      .cmd_o      (addrCmd),
      .sparse_o   (sparseWord),
      .macGo_o    (macGo),
      .firstInp_o (firstInp),
      .wbGo_o     (wbGo),
      .biasCk_o   (biasCk_o),
      .biasSel_o  (biasSel_o),
      .done_o     (done_o)
   );

   //------------------------------------------------------------------------
   // Array side
   arrayReader u_arrayReader (
      .CLK       (CLK),
      .RST_l     (RST_l),
      .rdGo_i    (rdGo),
      .arrAck_i  (arrAck_i),
      .arrData_i (arrData_i),
      .arrReq_o  (arrReq_o),
      .rdDone_o  (rdDone),
      .rdWord_o  (rdWord)
   );

   addrGen u_addrGen (
      .CLK        (CLK),
      .RST_l      (RST_l),
      .cmd_i      (addrCmd),
      .rdDone_i   (rdDone),
      .sparse_i   (sparseWord),
      .arStart_i  (arStart_i),
      .lbStart_i  (lbStart_i),
      .lbTemp_i   (lbTemp_i),
      .tempIdx_i  (tempIdx),
      .wbActive_i (wbActive),
      .arrAddr_o  (arrAddr_o),
      .lbAddr_o   (lbAddr_o)
   );

   //------------------------------------------------------------------------
   // MAC and line buffer
   macSeq #(
      .MultSteps (MultSteps)
   ) u_macSeq (
      .CLK         (CLK),
      .RST_l       (RST_l),
      .macGo_i     (macGo),
      .firstInp_i  (firstInp),
      .resetAcc_o  (resetAcc_o),
      .resetMult_o (resetMult_o),
      .lbRead_o    (lbRead_o),
      .latchMult_o (latchMult_o),
      .latchAcc_o  (latchAcc_o),
      .macDone_o   (macDone)
   );

   // Write index restarts with each layer
   lbWriteback u_lbWriteback (
      .CLK        (CLK),
      .RST_l      (RST_l),
      .wbGo_i     (wbGo),
      .clrIdx_i   (addrCmd.clrLayer),
      .lbWrite_o  (lbWrite_o),
      .macBusEn_o (macBusEn_o),
      .macSel_o   (macSel_o),
      .tempIdx_o  (tempIdx),
      .wbActive_o (wbActive),
      .wbDone_o   (wbDone)
   );

endmodule

// File: hdl/infPkg.sv
// Shared widths, array word layouts and internal control structs of the
// inference sequencing controller. Imported by every RTL module.
package infPkg;

   localparam int ArrAddrW  = 16;
   localparam int LbAddrW   = 10;
   localparam int DataW     = 32;
   localparam int NeuW      = 8;
   localparam int MacLanes  = 4;
   localparam int SparseIdx = 3;

   // First word of a layer
   typedef struct packed {
      logic        sparse;
      logic [1:0]  biasCnt;
      logic [28:0] rsvd;
   } layerHdr_t;

   // Second word of a layer
   typedef struct packed {
      logic [15:0]     rsvd;
      logic [NeuW-1:0] inpNeu;
      logic [NeuW-1:0] outNeu;
   } layerDim_t;

   // Slot 0 sits in the low bits
   typedef struct packed {
      logic [1:0]                           used;
      logic [SparseIdx-1:0][LbAddrW-1:0]    idx;
   } sparseWord_t;

   // Decoding depends on the fetch phase
   typedef union packed {
      layerHdr_t   hdr;
      layerDim_t   dim;
      sparseWord_t sp;
   } arrayWord_u;

   // One-cycle address commands, slot selects the sparse index
   typedef struct packed {
      logic       clrLayer;
      logic       clrNeuron;
      logic       loadDense;
      logic       loadSparse;
      logic [1:0] slot;
   } addrCmd_t;

endpackage

// File: hdl/layerSeq.sv
// Layer FSM. Fetches header and dimensions, then per output neuron runs the
// sparse fetch, weight reads with MAC bursts, bias reads and writeback.
`timescale 1ns/10ps

module layerSeq (
   input  logic                        CLK,
   input  logic                        RST_l,
   input  logic                        sts_i,
   input  logic                        rdDone_i,
   input  infPkg::arrayWord_u          rdWord_i,
   input  logic                        macDone_i,
   input  logic                        wbDone_i,
   output logic                        rdGo_o,
   output infPkg::addrCmd_t            cmd_o,
   output infPkg::sparseWord_t         sparse_o,
   output logic                        macGo_o,
   output logic                        firstInp_o,
   output logic                        wbGo_o,
   output logic [infPkg::MacLanes-1:0] biasCk_o,
   output logic                        biasSel_o,
   output logic                        done_o
);
   import infPkg::*;

   typedef enum logic [3:0] {
      sIdle,
      sHdr,
      sDim,
      sNeuron,
      sSparse,
      sInput,
      sWeight,
      sMac,
      sBias,
      sBiasRd,
      sWb
   } state_t;

   state_t          state;
   logic            sparseMode;
   logic [1:0]      biasCnt;
   logic [NeuW-1:0] outNeu;
   logic [NeuW-1:0] inpTotal;
   logic [NeuW-1:0] neuCnt;
   logic [NeuW-1:0] inpCnt;
   logic [1:0]      biasIdx;
   logic            firstPend;

   always_ff @(posedge CLK) begin
      if (RST_l) begin
         state      <= sIdle;
         rdGo_o     <= 1'b0;
         cmd_o      <= '0;
         macGo_o    <= 1'b0;
         firstInp_o <= 1'b0;
         wbGo_o     <= 1'b0;
         biasCk_o   <= '0;
         biasSel_o  <= 1'b0;
         done_o     <= 1'b0;
         neuCnt     <= '0;
         inpCnt     <= '0;
         biasIdx    <= '0;
         firstPend  <= 1'b0;
      end else begin
         // Strobes last one cycle
         rdGo_o     <= 1'b0;
         macGo_o    <= 1'b0;
         wbGo_o     <= 1'b0;
         biasCk_o   <= '0;
         cmd_o      <= '0;
         cmd_o.slot <= inpCnt[1:0];

         case (state)
            //---------------------------------------------------------------------
            // Layer fetch
            sIdle: begin
               if (sts_i) begin
                  done_o         <= 1'b0;
                  cmd_o.clrLayer <= 1'b1;
                  rdGo_o         <= 1'b1;
                  state          <= sHdr;
               end
            end
            sHdr: begin
               if (rdDone_i) begin
                  sparseMode <= rdWord_i.hdr.sparse;
                  biasCnt    <= rdWord_i.hdr.biasCnt;
                  rdGo_o     <= 1'b1;
                  state      <= sDim;
               end
            end
            sDim: begin
               if (rdDone_i) begin
                  outNeu   <= rdWord_i.dim.outNeu;
                  inpTotal <= rdWord_i.dim.inpNeu;
                  neuCnt   <= '0;
                  state    <= sNeuron;
               end
            end
            //---------------------------------------------------------------------
            // Per output neuron
            sNeuron: begin
               if (neuCnt == outNeu) begin
                  done_o <= 1'b1;
                  state  <= sIdle;
               end else begin
                  cmd_o.clrNeuron <= 1'b1;
                  inpCnt          <= '0;
                  firstPend       <= 1'b1;
                  if (sparseMode) begin
                     rdGo_o <= 1'b1;
                     state  <= sSparse;
                  end else begin
                     state <= sInput;
                  end
               end
            end
            sSparse: begin
               // Sparse neuron uses only the indices of its own word
               if (rdDone_i) begin
                  sparse_o <= rdWord_i.sp;
                  inpTotal <= NeuW'(rdWord_i.sp.used);
                  state    <= sInput;
               end
            end
            sInput: begin
               if (inpCnt < inpTotal) begin
                  rdGo_o <= 1'b1;
                  state  <= sWeight;
               end else begin
                  biasIdx   <= '0;
                  biasSel_o <= 1'b1;
                  state     <= sBias;
               end
            end
            sWeight: begin
               if (rdDone_i) begin
                  macGo_o          <= 1'b1;
                  firstInp_o       <= firstPend;
                  firstPend        <= 1'b0;
                  cmd_o.loadDense  <= !sparseMode;
                  cmd_o.loadSparse <= sparseMode;
                  state            <= sMac;
               end
            end
            sMac: begin
               if (macDone_i) begin
                  inpCnt <= inpCnt + 1'b1;
                  state  <= sInput;
               end
            end
            //---------------------------------------------------------------------
            // Bias words, then writeback
            sBias: begin
               if (biasIdx < biasCnt) begin
                  rdGo_o <= 1'b1;
                  state  <= sBiasRd;
               end else begin
                  biasSel_o <= 1'b0;
                  wbGo_o    <= 1'b1;
                  state     <= sWb;
               end
            end
            sBiasRd: begin
               if (rdDone_i) begin
                  biasCk_o[biasIdx] <= 1'b1;
                  biasIdx           <= biasIdx + 1'b1;
                  state             <= sBias;
               end
            end
            sWb: begin
               if (wbDone_i) begin
                  neuCnt <= neuCnt + 1'b1;
                  state  <= sNeuron;
               end
            end
            default: begin
               state <= sIdle;
            end
         endcase
      end
   end

endmodule

// File: hdl/lbWriteback.sv
// Writes the four MAC lanes to the temporary region, one write every other
// cycle, and keeps the write index that runs across the whole layer.
`timescale 1ns/10ps

module lbWriteback (
   input  logic                       CLK,
   input  logic                       RST_l,
   input  logic                       wbGo_i,
   input  logic                       clrIdx_i,
   output logic                       lbWrite_o,
   output logic                       macBusEn_o,
   output logic [1:0]                 macSel_o,
   output logic [infPkg::LbAddrW-1:0] tempIdx_o,
   output logic                       wbActive_o,
   output logic                       wbDone_o
);
   import infPkg::*;

   localparam int LaneW = $clog2(MacLanes);

   logic active;
   logic phase;

   always_ff @(posedge CLK) begin
      if (RST_l) begin
         active    <= 1'b0;
         phase     <= 1'b0;
         tempIdx_o <= '0;
      end else begin
         if (clrIdx_i) begin
            tempIdx_o <= '0;
         end else if (lbWrite_o) begin
            tempIdx_o <= tempIdx_o + 1'b1;
         end

         if (wbGo_i) begin
            active <= 1'b1;
            phase  <= 1'b0;
         end else if (active) begin
            phase <= !phase;
            if (wbDone_o) begin
               active <= 1'b0;
            end
         end
      end
   end

   // Index steps by MacLanes per neuron, so its low bits are the lane
   assign lbWrite_o  = active && phase;
   assign macSel_o   = active ? tempIdx_o[LaneW-1:0] : '0;
   assign macBusEn_o = active;
   assign wbActive_o = active;
   assign wbDone_o   = lbWrite_o && (tempIdx_o[LaneW-1:0] == LaneW'(MacLanes - 1));

endmodule

// File: hdl/macSeq.sv
// One MAC burst per macGo_i: reset and operand read, MultSteps multiply
// latches, then the accumulate latch together with macDone_o.
`timescale 1ns/10ps

module macSeq #(
   parameter int MultSteps = 9
) (
   input  logic CLK,
   input  logic RST_l,
   input  logic macGo_i,
   input  logic firstInp_i,
   output logic resetAcc_o,
   output logic resetMult_o,
   output logic lbRead_o,
   output logic latchMult_o,
   output logic latchAcc_o,
   output logic macDone_o
);
   localparam int StepW = $clog2(MultSteps + 2);

   logic             active;
   logic [StepW-1:0] step;
   logic             firstReg;

   always_ff @(posedge CLK) begin
      if (RST_l) begin
         active   <= 1'b0;
         step     <= '0;
         firstReg <= 1'b0;
      end else if (macGo_i) begin
         active   <= 1'b1;
         step     <= '0;
         firstReg <= firstInp_i;
      end else if (active) begin
         if (step == StepW'(MultSteps + 1)) begin
            active <= 1'b0;
         end
         step <= step + 1'b1;
      end
   end

   // Step 0 prepares the multiplier and fetches the operand
   assign resetMult_o = active && (step == '0);
   assign lbRead_o    = resetMult_o;
   assign resetAcc_o  = resetMult_o && firstReg;
   assign latchMult_o = active && (step != '0) && (step <= StepW'(MultSteps));
   assign latchAcc_o  = active && (step == StepW'(MultSteps + 1));
   assign macDone_o   = latchAcc_o;

endmodule

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module infCtrlTb -Mdir obj_dir \
   && ./obj_dir/VinfCtrlTb | tee /dev/stderr | grep -qx "Everything OK" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: tests/infCtrlTb.sv
// Testbench for the inference sequencing controller. Runs every layer of the
// stim file against a modeled array and checks addresses and strobes.
`timescale 1ns/10ps

module infCtrlTb;
   import infPkg::*;

   localparam int MultSteps = 9;
   localparam int ClkHalf   = 20;
   localparam int StimAw    = 8;

   typedef struct packed {
      logic [LbAddrW-1:0] addr;
      logic [1:0]         sel;
   } wrExp_t;

   logic                CLK       = 1'b0;
   logic                RST_l;
   logic                sts_i;
   logic [ArrAddrW-1:0] arStart_i;
   logic [LbAddrW-1:0]  lbStart_i;
   logic [LbAddrW-1:0]  lbTemp_i;
   logic                arrAck_i  = 1'b0;
   logic [DataW-1:0]    arrData_i = '0;
   logic                arrReq_o;
   logic [ArrAddrW-1:0] arrAddr_o;
   logic [LbAddrW-1:0]  lbAddr_o;
   logic                lbRead_o;
   logic                lbWrite_o;
   logic                resetAcc_o;
   logic                resetMult_o;
   logic                latchMult_o;
   logic                latchAcc_o;
   logic                macBusEn_o;
   logic [1:0]          macSel_o;
   logic [MacLanes-1:0] biasCk_o;
   logic                biasSel_o;
   logic                done_o;

   logic [31:0]         stim [0:(1<<StimAw)-1];
   logic [31:0]         lfsr        = 32'hc778fbbe;
   logic                reqSeen     = 1'b0;
   logic [1:0]          delayLeft   = 2'd0;
   logic                inBurst     = 1'b0;
   int                  multCnt     = 0;
   int                  layerReads  = 0;
   int                  curBase     = 0;
   int                  curWordCnt  = 0;
   int                  limitCycles = 0;
   int                  checkCnt    = 0;
   int                  errCnt      = 0;
   logic [LbAddrW-1:0]  expRead[$];
   logic                expFirst[$];
   logic [MacLanes-1:0] expBias[$];
   wrExp_t              expWrite[$];

   always #(ClkHalf) CLK = ~CLK;

   infCtrlTop #(
      .MultSteps (MultSteps)
   ) u_infCtrlTop (
      .CLK         (CLK),
      .RST_l       (RST_l),
      .sts_i       (sts_i),
      .arStart_i   (arStart_i),
      .lbStart_i   (lbStart_i),
      .lbTemp_i    (lbTemp_i),
      .arrAck_i    (arrAck_i),
      .arrData_i   (arrData_i),
      .arrReq_o    (arrReq_o),
      .arrAddr_o   (arrAddr_o),
      .lbAddr_o    (lbAddr_o),
      .lbRead_o    (lbRead_o),
      .lbWrite_o   (lbWrite_o),
      .resetAcc_o  (resetAcc_o),
      .resetMult_o (resetMult_o),
      .latchMult_o (latchMult_o),
      .latchAcc_o  (latchAcc_o),
      .macBusEn_o  (macBusEn_o),
      .macSel_o    (macSel_o),
      .biasCk_o    (biasCk_o),
      .biasSel_o   (biasSel_o),
      .done_o      (done_o)
   );

   // --------------------------------------------------------------------------
   // Helpers
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per delay bit
   task automatic drawDelay(output logic [1:0] d);
      d = 2'd0;
      repeat (2) begin
         d    = {d[0], lfsr[0]};
         lfsr = lfsrNext(lfsr);
      end
   endtask

   function automatic logic [31:0] stimAt(input int i);
      return stim[StimAw'(i)];
   endfunction

   // Record words inside the layer and an address-based fill outside it
   function automatic logic [31:0] arrayContent(input logic [ArrAddrW-1:0] addr);
      logic [ArrAddrW-1:0] ofs;
      ofs = addr - arStart_i;
      if (int'(ofs) < curWordCnt) begin
         return stimAt(curBase + int'(ofs));
      end
      return {~addr, addr};
   endfunction

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] want);
      checkCnt++;
      if (got !== want) begin
         errCnt++;
         $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
      end
   endtask

   task automatic reportFault(input string what);
      errCnt++;
      $display("Failure at %0t ns: %s", $time, what);
   endtask

   // Expected strobes of one layer from the word layouts
   task automatic buildExpect(input int recBase, output int expReads);
      logic [31:0]         hdr;
      logic [31:0]         dim;
      logic [31:0]         sw;
      logic [LbAddrW-1:0]  lbStart;
      logic [LbAddrW-1:0]  lbTemp;
      logic [LbAddrW-1:0]  opAddr;
      logic [MacLanes-1:0] oneHot;
      wrExp_t              wr;
      int                  idx;
      int                  nUsed;
      int                  wIdx;

      lbStart = LbAddrW'(stimAt(recBase + 1));
      lbTemp  = LbAddrW'(stimAt(recBase + 2));
      hdr     = stimAt(recBase + 4);
      dim     = stimAt(recBase + 5);
      idx     = 2;
      wIdx    = 0;
      for (int n = 0; n < int'(dim[7:0]); n++) begin
         if (hdr[31]) begin
            sw    = stimAt(recBase + 4 + idx);
            idx   = idx + 1;
            nUsed = int'(sw[31:30]);
            for (int s = 0; s < nUsed; s++) begin
               opAddr = lbStart + 10'(sw >> (10 * s));
               expRead.push_back(opAddr);
               expFirst.push_back(s == 0);
            end
         end else begin
            nUsed = int'(dim[15:8]);
            for (int k = 0; k < nUsed; k++) begin
               opAddr = lbStart + LbAddrW'(k);
               expRead.push_back(opAddr);
               expFirst.push_back(k == 0);
            end
         end
         idx = idx + nUsed + int'(hdr[30:29]);
         for (int b = 0; b < int'(hdr[30:29]); b++) begin
            oneHot = MacLanes'(1) << b;
            expBias.push_back(oneHot);
         end
         for (int lane = 0; lane < MacLanes; lane++) begin
            wr.addr = lbTemp + LbAddrW'(wIdx);
            wr.sel  = 2'(lane);
            expWrite.push_back(wr);
            wIdx++;
         end
      end
      expReads = idx;
   endtask

   task automatic runLayer(input int recBase);
      int wordCnt;
      int expReads;

      wordCnt = int'(stimAt(recBase + 3));
      buildExpect(recBase, expReads);
      if (expReads != wordCnt) reportFault("stim record length does not fit its layer");
      @(negedge CLK);
      arStart_i  <= ArrAddrW'(stimAt(recBase));
      lbStart_i  <= LbAddrW'(stimAt(recBase + 1));
      lbTemp_i   <= LbAddrW'(stimAt(recBase + 2));
      curBase    = recBase + 4;
      curWordCnt = wordCnt;
      sts_i      <= 1'b1;
      @(negedge CLK);
      sts_i <= 1'b0;
      while (!done_o) begin
         @(negedge CLK);
      end
      checkEq("array read count", 32'(layerReads), 32'(expReads));
      if (expRead.size() + expFirst.size() + expBias.size() + expWrite.size() != 0) begin
         reportFault("expected strobes still pending when done_o rose");
      end
      expRead.delete();
      expFirst.delete();
      expBias.delete();
      expWrite.delete();
      // Done stays up while start is low
      repeat (4) begin
         @(negedge CLK);
         checkEq("done_o", 32'(done_o), 32'd1);
      end
   endtask

   // --------------------------------------------------------------------------
   // Array model and strobe checkers sampled on the falling edge
   always @(negedge CLK) begin
      logic [ArrAddrW-1:0] expAddr;
      logic [LbAddrW-1:0]  rdAddr;
      logic [MacLanes-1:0] bias;
      logic                isFirst;
      wrExp_t              wr;

      if (!RST_l) begin
         if (sts_i) layerReads = 0;
         if (arrReq_o && !arrAck_i) begin
            if (!reqSeen) begin
               reqSeen = 1'b1;
               drawDelay(delayLeft);
               expAddr = arStart_i + ArrAddrW'(layerReads);
               checkEq("arrAddr_o", 32'(arrAddr_o), 32'(expAddr));
               layerReads++;
            end
            if (delayLeft == 2'd0) begin
               arrAck_i  <= 1'b1;
               arrData_i <= arrayContent(arrAddr_o);
            end else begin
               delayLeft = delayLeft - 2'd1;
            end
         end else if (arrAck_i) begin
            // Request drops on the cycle after the acknowledge
            checkEq("arrReq_o", 32'(arrReq_o), 32'd0);
            arrAck_i <= 1'b0;
            reqSeen  = 1'b0;
         end else if (reqSeen) begin
            reportFault("arrReq_o dropped before its acknowledge");
            reqSeen = 1'b0;
         end

         if (resetMult_o) begin
            if (inBurst) reportFault("MAC burst restarted before its accumulate latch");
            inBurst = 1'b1;
            multCnt = 0;
            checkEq("biasSel_o", 32'(biasSel_o), 32'd0);
            if (expFirst.size() == 0) begin
               reportFault("resetMult_o pulsed with no MAC burst left");
            end else begin
               isFirst = expFirst.pop_front();
               checkEq("resetAcc_o", 32'(resetAcc_o), 32'(isFirst));
            end
         end else if (resetAcc_o) begin
            reportFault("resetAcc_o pulsed outside a burst start");
         end
         if (latchMult_o) begin
            if (!inBurst) reportFault("latchMult_o pulsed outside a MAC burst");
            multCnt++;
         end
         if (latchAcc_o) begin
            if (!inBurst) reportFault("latchAcc_o pulsed outside a MAC burst");
            checkEq("latchMult_o count", 32'(multCnt), 32'(MultSteps));
            inBurst = 1'b0;
         end

         if (lbRead_o) begin
            if (expRead.size() == 0) begin
               reportFault("unexpected line-buffer read");
            end else begin
               rdAddr = expRead.pop_front();
               checkEq("lbAddr_o", 32'(lbAddr_o), 32'(rdAddr));
            end
         end
         if (biasCk_o != '0) begin
            checkEq("biasSel_o", 32'(biasSel_o), 32'd1);
            if (expBias.size() == 0) begin
               reportFault("unexpected bias clock");
            end else begin
               bias = expBias.pop_front();
               checkEq("biasCk_o", 32'(biasCk_o), 32'(bias));
            end
         end
         if (lbWrite_o) begin
            checkEq("macBusEn_o", 32'(macBusEn_o), 32'd1);
            if (expWrite.size() == 0) begin
               reportFault("unexpected line-buffer write");
            end else begin
               wr = expWrite.pop_front();
               checkEq("lbAddr_o", 32'(lbAddr_o), 32'(wr.addr));
               checkEq("macSel_o", 32'(macSel_o), 32'(wr.sel));
            end
         end
      end
   end

   // --------------------------------------------------------------------------
   // Watchdog
   initial begin
      wait (limitCycles > 0);
      repeat (limitCycles) @(posedge CLK);
      $display("Timeout after %0d cycles with %0d errors", limitCycles, errCnt);
      $display("Something failed");
      $finish;
   end

   initial begin
      int nRec;
      int base;
      int totalWords;

      RST_l     = 1'b1;
      sts_i     = 1'b0;
      arStart_i = '0;
      lbStart_i = '0;
      lbTemp_i  = '0;
      $readmemh("tests/infStim.hex", stim);
      nRec       = int'(stimAt(0));
      base       = 1;
      totalWords = 0;
      for (int r = 0; r < nRec; r++) begin
         totalWords = totalWords + int'(stimAt(base + 3));
         base       = base + 4 + int'(stimAt(base + 3));
      end
      // Room per word for the ack delay, one MAC burst and a share of writeback
      limitCycles = 200 + totalWords * (MultSteps + 40);

      repeat (2) @(posedge CLK);
      @(negedge CLK);
      RST_l <= 1'b0;
      @(negedge CLK);
      checkEq("outputs after reset", 32'({done_o, arrReq_o, biasSel_o, macBusEn_o, biasCk_o,
         lbRead_o, lbWrite_o, resetAcc_o, resetMult_o, latchMult_o, latchAcc_o}), 32'd0);

      base = 1;
      for (int r = 0; r < nRec; r++) begin
         runLayer(base);
         base = base + 4 + int'(stimAt(base + 3));
      end

      $display("Layers: %0d, checks: %0d, errors: %0d", nRec, checkCnt, errCnt);
      if (errCnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: tests/infStim.hex
// Record: arStart lbStart lbTemp wordCount, then wordCount array words
// starting with the layer header and dimension words. First value is the record count.
00000004
// Dense, 2 outputs x 3 inputs, 2 bias words
00001200 00000040 00000300 0000000c
40000000 00000302
a0000001 a0000002 a0000003 b0000001 b0000002
a0000011 a0000012 a0000013 b0000011 b0000012
// Sparse, 3 outputs using 3, 1 and 2 indices, 1 bias word, addresses wrap
0000fff8 000003f8 00000200 0000000e
a0000000 00000503
c2104805 a0000101 a0000102 a0000103 b0000101
4002a900 a0000111 b0000111
955fc007 a0000121 a0000122 b0000121
// Dense with reserved bits set, 1 output x 2 inputs, no bias, temp region wraps
00000040 00000000 000003fe 00000004
12345678 abcd0201 a0000201 a0000202
// Sparse, 1 output using 2 indices, 3 bias words
00002000 00000100 00000080 00000008
e0000000 00000001 80008010 a0000301 a0000302 b0000301 b0000302 b0000303
